/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int XLEN       = 32;  // data and address width
  localparam int REG_ADDR_W = 5;   // x0..x31

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // register-register alu
    OPC_OP_IMM = 7'b0010011,  // addi and friends
    OPC_LOAD   = 7'b0000011,  // lw
    OPC_STORE  = 7'b0100011,  // sw
    OPC_BRANCH = 7'b1100011,  // beq / bne
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011   // ecall
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT   // signed compare
  } alu_op_e;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;  // funct7[5] picks sub
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [REG_ADDR_W-1:0] HALT_REG  = 5'd17;   // a7 carries the ecall code
  localparam logic [XLEN-1:0]       HALT_CODE = 32'd10;  // exit request

endpackage

`default_nettype wire

/* rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall,        // load-use hold from decode
  input  logic                    redirect,     // taken branch or jal in EX
  input  logic [rv_pkg::XLEN-1:0] redirect_pc,
  input  logic [rv_pkg::XLEN-1:0] imem_data,
  output logic [rv_pkg::XLEN-1:0] imem_addr,
  output logic [rv_pkg::XLEN-1:0] if_inst,
  output logic [rv_pkg::XLEN-1:0] if_pc,
  output logic                    if_valid
);

  logic [rv_pkg::XLEN-1:0] pc;

  assign imem_addr = pc;  // imem answers in the same cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;  // redirect wins over hold
    end else if (!stall) begin
      pc <= pc + 4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      if_valid <= 1'b0;
    end else if (redirect) begin
      if_valid <= 1'b0;  // kill wrong-path fetch
    end else if (!stall) begin
      if_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      if_inst <= imem_data;
      if_pc   <= pc;
    end
  end

  // a load in EX can never be the redirecting instruction
  assert property (@(posedge clk) disable iff (reset) !(stall && redirect))
    else $error("stall and redirect high in the same cycle");

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [rv_pkg::XLEN-1:0]       if_inst,
  input  logic [rv_pkg::XLEN-1:0]       if_pc,
  input  logic                          if_valid,
  input  logic                          redirect,
  input  logic                          wb_valid,       // regfile write port
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
  input  logic [rv_pkg::XLEN-1:0]       wb_data,
  input  logic [rv_pkg::REG_ADDR_W-1:0] mem_rd,         // EX/MEM destination
  input  logic                          mem_reg_write,
  input  logic [rv_pkg::XLEN-1:0]       mem_alu_out,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_in,       // ID/EX destination seen by EX
  output logic                          stall,
  output logic                          ex_valid,
  output rv_pkg::alu_op_e               ex_alu_op,
  output logic                          ex_alu_src,
  output logic                          ex_mem_read,
  output logic                          ex_mem_write,
  output logic                          ex_reg_write,
  output logic                          ex_is_branch,
  output logic                          ex_branch_ne,
  output logic                          ex_is_jal,
  output logic                          ex_halt,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rs2,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rd,
  output logic [rv_pkg::XLEN-1:0]       ex_rs1_data,
  output logic [rv_pkg::XLEN-1:0]       ex_rs2_data,
  output logic [rv_pkg::XLEN-1:0]       ex_imm,
  output logic [rv_pkg::XLEN-1:0]       ex_pc
);

  rv_pkg::opcode_e                 opcode;
  rv_pkg::alu_op_e                 alu_op;
  logic [rv_pkg::REG_ADDR_W-1:0]   rs1;
  logic [rv_pkg::REG_ADDR_W-1:0]   rs2;
  logic [rv_pkg::REG_ADDR_W-1:0]   rd;
  logic [2:0]                      funct3;
  logic [rv_pkg::XLEN-1:0]         imm;
  logic [rv_pkg::XLEN-1:0]         x17_val;
  logic [rv_pkg::XLEN-1:0]         regs [2**rv_pkg::REG_ADDR_W];
  logic alu_src;
  logic mem_read;
  logic mem_write;
  logic reg_wr;
  logic is_branch;
  logic is_jal;
  logic is_sys;
  logic uses_rs1;
  logic uses_rs2;
  logic load_use;
  logic x17_wait;
  logic issue;
  logic mem_load;  // EX/MEM slot holds a load

  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
    case (f3)
      rv_pkg::F3_ADD_SUB: return sub ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      rv_pkg::F3_SLT:     return rv_pkg::ALU_SLT;
      rv_pkg::F3_XOR:     return rv_pkg::ALU_XOR;
      rv_pkg::F3_OR:      return rv_pkg::ALU_OR;
      rv_pkg::F3_AND:     return rv_pkg::ALU_AND;
      default:            return rv_pkg::ALU_ADD;
    endcase
  endfunction

  // read with bypass of the write landing on this edge
  function automatic logic [rv_pkg::XLEN-1:0] rf_read(
    input logic [rv_pkg::REG_ADDR_W-1:0] idx
  );
    if (wb_valid && wb_rd == idx) return wb_data;
    return regs[idx];
  endfunction

  assign opcode = rv_pkg::opcode_e'(if_inst[6:0]);
  assign rd     = if_inst[11:7];
  assign funct3 = if_inst[14:12];
  assign rs1    = if_inst[19:15];
  assign rs2    = if_inst[24:20];

  always_comb begin
    alu_op    = rv_pkg::ALU_ADD;
    alu_src   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_wr    = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_sys    = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    imm       = {{20{if_inst[31]}}, if_inst[31:20]};  // I-type
    case (opcode)
      rv_pkg::OPC_OP: begin
        alu_op   = alu_sel(funct3, if_inst[30]);
        reg_wr   = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        alu_op   = alu_sel(funct3, 1'b0);  // no subi
        alu_src  = 1'b1;
        reg_wr   = 1'b1;
        uses_rs1 = 1'b1;
      end
      rv_pkg::OPC_LOAD: begin
        alu_src  = 1'b1;
        mem_read = 1'b1;
        reg_wr   = 1'b1;
        uses_rs1 = 1'b1;
      end
      rv_pkg::OPC_STORE: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;  // store data
        imm       = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
      end
      rv_pkg::OPC_BRANCH: begin
        is_branch = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25], if_inst[11:8], 1'b0};
      end
      rv_pkg::OPC_JAL: begin
        is_jal = 1'b1;
        reg_wr = 1'b1;
        imm = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20], if_inst[30:21], 1'b0};
      end
      rv_pkg::OPC_SYSTEM: is_sys = 1'b1;
      default: ;  // unsupported opcodes retire as nops
    endcase
  end

  always_comb begin
    x17_val = rf_read(rv_pkg::HALT_REG);
    if (mem_reg_write && mem_rd == rv_pkg::HALT_REG) begin
      x17_val = mem_alu_out;  // newer value still in EX/MEM
    end
  end

  assign load_use = ex_mem_read && ex_reg_write &&
                    ((uses_rs1 && rs1 == ex_rd_in) || (uses_rs2 && rs2 == ex_rd_in));
  // a7 still being produced in EX, or loaded in MEM
  assign x17_wait = is_sys && !redirect &&
                    ((ex_reg_write && ex_rd_in == rv_pkg::HALT_REG) ||
                     (mem_load && mem_reg_write && mem_rd == rv_pkg::HALT_REG));
  assign stall    = if_valid && (load_use || x17_wait);
  assign issue    = if_valid && !stall && !redirect;  // else a bubble enters EX

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**rv_pkg::REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid) begin
      regs[wb_rd] <= wb_data;  // wb_rd is never x0
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid     <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_is_branch <= 1'b0;
      ex_is_jal    <= 1'b0;
      ex_halt      <= 1'b0;
      mem_load     <= 1'b0;
    end else begin
      ex_valid     <= issue;
      ex_mem_read  <= issue && mem_read;
      ex_mem_write <= issue && mem_write;
      ex_reg_write <= issue && reg_wr && (rd != '0);  // x0 writes dropped here
      ex_is_branch <= issue && is_branch;
      ex_is_jal    <= issue && is_jal;
      ex_halt      <= issue && is_sys && (x17_val == rv_pkg::HALT_CODE);
      mem_load     <= ex_mem_read;  // follows the load into EX/MEM
    end
  end

  always_ff @(posedge clk) begin
    ex_alu_op    <= alu_op;
    ex_alu_src   <= alu_src;
    ex_branch_ne <= funct3[0];  // bne
    ex_rs1       <= rs1;
    ex_rs2       <= rs2;
    ex_rd        <= rd;
    ex_rs1_data  <= rf_read(rs1);
    ex_rs2_data  <= rf_read(rs2);
    ex_imm       <= imm;
    ex_pc        <= if_pc;
  end

  // full ecall encoding, the decoder itself only looks at the opcode
  assert property (@(posedge clk) disable iff (reset)
    ex_halt |-> ex_valid && $past(if_inst) == {25'b0, rv_pkg::OPC_SYSTEM})
    else $error("halt raised by a slot that was not a valid ecall");

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          ex_valid,
  input  rv_pkg::alu_op_e               ex_alu_op,
  input  logic                          ex_alu_src,
  input  logic                          ex_mem_read,
  input  logic                          ex_mem_write,
  input  logic                          ex_reg_write,
  input  logic                          ex_is_branch,
  input  logic                          ex_branch_ne,
  input  logic                          ex_is_jal,
  input  logic                          ex_halt,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs2,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd,
  input  logic [rv_pkg::XLEN-1:0]       ex_rs1_data,
  input  logic [rv_pkg::XLEN-1:0]       ex_rs2_data,
  input  logic [rv_pkg::XLEN-1:0]       ex_imm,
  input  logic [rv_pkg::XLEN-1:0]       ex_pc,
  input  logic                          wb_valid,     // MEM/WB forwarding source
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
  input  logic [rv_pkg::XLEN-1:0]       wb_data,
  output logic                          redirect,
  output logic [rv_pkg::XLEN-1:0]       redirect_pc,
  output logic                          mem_valid,
  output logic                          mem_mem_read,
  output logic                          mem_mem_write,
  output logic                          mem_reg_write,
  output logic                          mem_halt,
  output logic                          mem_is_jal,
  output logic [rv_pkg::REG_ADDR_W-1:0] mem_rd,
  output logic [rv_pkg::XLEN-1:0]       mem_alu_out,
  output logic [rv_pkg::XLEN-1:0]       mem_store_data,
  output logic [rv_pkg::XLEN-1:0]       mem_link_pc
);

  logic [rv_pkg::XLEN-1:0] mem_fwd;
  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b_reg;  // rs2 after forwarding
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] alu_out;
  logic                    taken;

  // EX/MEM is the younger producer, so it wins over write-back
  function automatic logic [rv_pkg::XLEN-1:0] fwd(
    input logic [rv_pkg::REG_ADDR_W-1:0] idx,
    input logic [rv_pkg::XLEN-1:0]       reg_val
  );
    if (mem_reg_write && mem_rd == idx) return mem_fwd;
    if (wb_valid && wb_rd == idx) return wb_data;
    return reg_val;
  endfunction

  assign mem_fwd = mem_is_jal ? mem_link_pc : mem_alu_out;  // jal forwards its link

  always_comb begin
    op_a     = fwd(ex_rs1, ex_rs1_data);
    op_b_reg = fwd(ex_rs2, ex_rs2_data);
    op_b     = ex_alu_src ? ex_imm : op_b_reg;
    case (ex_alu_op)
      rv_pkg::ALU_ADD: alu_out = op_a + op_b;
      rv_pkg::ALU_SUB: alu_out = op_a - op_b;
      rv_pkg::ALU_AND: alu_out = op_a & op_b;
      rv_pkg::ALU_OR:  alu_out = op_a | op_b;
      rv_pkg::ALU_XOR: alu_out = op_a ^ op_b;
      rv_pkg::ALU_SLT: alu_out = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default:         alu_out = op_a + op_b;
    endcase
  end

  assign taken       = ex_is_branch && ((op_a == op_b_reg) != ex_branch_ne);  // beq / bne
  assign redirect    = ex_valid && (ex_is_jal || taken);  // not-taken assumed at fetch
  assign redirect_pc = ex_pc + ex_imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid     <= 1'b0;
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
      mem_reg_write <= 1'b0;
      mem_halt      <= 1'b0;
      mem_is_jal    <= 1'b0;
    end else begin
      mem_valid     <= ex_valid;
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
      mem_reg_write <= ex_reg_write;
      mem_halt      <= ex_halt;
      mem_is_jal    <= ex_is_jal;
    end
  end

  always_ff @(posedge clk) begin
    mem_rd         <= ex_rd;
    mem_alu_out    <= alu_out;  // also the lw / sw address
    mem_store_data <= op_b_reg;
    mem_link_pc    <= ex_pc + 4;
  end

  // control flow only, and decode must bubble the slot behind it
  assert property (@(posedge clk) disable iff (reset)
    redirect |-> (ex_is_branch || ex_is_jal) ##1 !ex_valid)
    else $error("redirect without a flushed control-flow instruction");

endmodule

`default_nettype wire

/* rv_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_memory #(
  parameter int DMEM_WORDS = 64  // power of two
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          mem_valid,
  input  logic                          mem_mem_read,
  input  logic                          mem_mem_write,
  input  logic                          mem_reg_write,
  input  logic                          mem_halt,
  input  logic                          mem_is_jal,
  input  logic [rv_pkg::REG_ADDR_W-1:0] mem_rd,
  input  logic [rv_pkg::XLEN-1:0]       mem_alu_out,
  input  logic [rv_pkg::XLEN-1:0]       mem_store_data,
  input  logic [rv_pkg::XLEN-1:0]       mem_link_pc,
  output logic                          wb_valid,
  output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [rv_pkg::XLEN-1:0]       wb_data,
  output logic                          halted
);

  localparam int AW = $clog2(DMEM_WORDS);

  logic [rv_pkg::XLEN-1:0] dmem [DMEM_WORDS];
  logic [AW-1:0]           idx;
  logic [rv_pkg::XLEN-1:0] load_data;

  assign idx       = mem_alu_out[AW+1:2];  // word address wraps at DMEM_WORDS
  assign load_data = dmem[idx];            // async read

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (mem_valid && mem_mem_write && !halted) begin
      dmem[idx] <= mem_store_data;  // no stores once halted
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
      halted   <= 1'b0;
    end else begin
      wb_valid <= mem_valid && mem_reg_write && !halted;
      halted   <= halted || (mem_valid && mem_halt);  // sticky
    end
  end

  always_ff @(posedge clk) begin
    wb_rd <= mem_rd;
    if (mem_mem_read) begin
      wb_data <= load_data;
    end else if (mem_is_jal) begin
      wb_data <= mem_link_pc;  // pc + 4
    end else begin
      wb_data <= mem_alu_out;
    end
  end

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter int DMEM_WORDS = 64  // data memory depth in words
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [rv_pkg::XLEN-1:0]       imem_data,
  output logic [rv_pkg::XLEN-1:0]       imem_addr,
  output logic                          wb_valid,
  output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [rv_pkg::XLEN-1:0]       wb_data,
  output logic                          halted
);

  // IF/ID and fetch control
  logic [rv_pkg::XLEN-1:0]       if_inst;
  logic [rv_pkg::XLEN-1:0]       if_pc;
  logic                          if_valid;
  logic                          stall;
  logic                          redirect;
  logic [rv_pkg::XLEN-1:0]       redirect_pc;

  // ID/EX
  logic                          ex_valid;
  rv_pkg::alu_op_e               ex_alu_op;
  logic                          ex_alu_src;
  logic                          ex_mem_read;
  logic                          ex_mem_write;
  logic                          ex_reg_write;
  logic                          ex_is_branch;
  logic                          ex_branch_ne;
  logic                          ex_is_jal;
  logic                          ex_halt;
  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1;
  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs2;
  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd;
  logic [rv_pkg::XLEN-1:0]       ex_rs1_data;
  logic [rv_pkg::XLEN-1:0]       ex_rs2_data;
  logic [rv_pkg::XLEN-1:0]       ex_imm;
  logic [rv_pkg::XLEN-1:0]       ex_pc;

  // EX/MEM
  logic                          mem_valid;
  logic                          mem_mem_read;
  logic                          mem_mem_write;
  logic                          mem_reg_write;
  logic                          mem_halt;
  logic                          mem_is_jal;
  logic [rv_pkg::REG_ADDR_W-1:0] mem_rd;
  logic [rv_pkg::XLEN-1:0]       mem_alu_out;
  logic [rv_pkg::XLEN-1:0]       mem_store_data;
  logic [rv_pkg::XLEN-1:0]       mem_link_pc;

  rv_fetch u_fetch (.*);

  rv_decode u_decode (
    .*,
    .ex_rd_in (ex_rd)  // hazard compare against the slot now in EX
  );

  rv_execute u_execute (.*);

  rv_memory #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_memory (.*);

endmodule

`default_nettype wire

/* tb_rv_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_checker #(
  parameter int PROG_WORDS = 48,
  parameter int DMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [rv_pkg::XLEN-1:0]       program_mem [PROG_WORDS],
  input  logic                          wb_valid,
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
  input  logic [rv_pkg::XLEN-1:0]       wb_data,
  input  logic                          halted,
  output logic                          check_done,
  output int                            error_count,
  output int                            wb_count
);

  localparam int RESET_LIMIT  = 20;    // cycles until reset must drop
  localparam int WB_LIMIT     = 100;   // max gap between write-backs
  localparam int QUIET_CYCLES = 20;    // watched after halt
  localparam int STEP_LIMIT   = 1000;  // model runaway guard

  logic [31:0] m_regs [32];
  logic [31:0] m_mem  [DMEM_WORDS];
  logic [31:0] m_pc;
  logic [4:0]  exp_rd;
  logic [31:0] exp_val;
  logic        exp_halt;
  int          cycles;

  // run the ISA model up to its next register write; returns 1 once halted
  function automatic logic model_next_write(output logic [4:0] rd, output logic [31:0] val);
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] next_pc;
    logic [2:0]  f3;
    int          widx;
    rd  = '0;
    val = '0;
    for (int step = 0; step < STEP_LIMIT; step++) begin
      inst    = ((m_pc >> 2) < PROG_WORDS) ? program_mem[m_pc >> 2] : 32'h0000_0013;
      f3      = inst[14:12];
      a       = m_regs[inst[19:15]];
      b       = m_regs[inst[24:20]];
      imm_i   = {{20{inst[31]}}, inst[31:20]};
      next_pc = m_pc + 4;
      rd      = inst[11:7];
      case (inst[6:0])
        7'b0110011: begin
          case ({inst[30], f3})
            4'b0000: val = a + b;
            4'b1000: val = a - b;
            4'b0010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'b0100: val = a ^ b;
            4'b0110: val = a | b;
            4'b0111: val = a & b;
            default: rd = '0;
          endcase
        end
        7'b0010011: val = a + imm_i;  // addi only
        7'b0000011: begin
          widx = int'(((a + imm_i) >> 2) % DMEM_WORDS);
          val  = m_mem[widx];
        end
        7'b0100011: begin
          widx = int'(((a + {{20{inst[31]}}, inst[31:25], inst[11:7]}) >> 2) % DMEM_WORDS);
          m_mem[widx] = b;
          rd = '0;
        end
        7'b1100011: begin
          if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin  // beq / bne
            next_pc = m_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
          end
          rd = '0;
        end
        7'b1101111: begin
          val     = m_pc + 4;  // link
          next_pc = m_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        7'b1110011: begin
          rd = '0;
          if (m_regs[17] == 32'd10) return 1'b1;  // exit ecall
        end
        default: rd = '0;
      endcase
      m_pc = next_pc;
      if (rd != 5'd0) begin
        m_regs[rd] = val;
        return 1'b0;
      end
    end
    return 1'b1;  // runaway program counts as halted
  endfunction

  task automatic expect_idle(input string phase);
    if (wb_valid !== 1'b0 || halted !== 1'b0) begin
      $display("Mismatch at %0t: wb_valid or halted not low %s", $time, phase);
      error_count++;
    end
  endtask

  initial begin
    check_done  = 1'b0;
    error_count = 0;
    wb_count    = 0;
    m_pc        = '0;
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++) m_mem[i] = '0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      expect_idle("during reset");
    end while (reset && cycles < RESET_LIMIT);
    if (reset) begin
      $display("reset was never released");
      error_count++;
    end else begin
      @(negedge clk);
      expect_idle("in the first cycle after reset");
      exp_halt = model_next_write(exp_rd, exp_val);
      cycles   = 0;
      while (!halted && cycles < WB_LIMIT) begin
        @(negedge clk);
        cycles++;
        if (wb_valid) begin
          cycles = 0;
          wb_count++;
          if (exp_halt) begin
            $display("Mismatch at %0t: write-back x%0d = %h after the model halted",
                     $time, wb_rd, wb_data);
            error_count++;
          end else begin
            if (wb_rd !== exp_rd || wb_data !== exp_val) begin
              $display("Mismatch at %0t: write-back %0d is x%0d = %h, expected x%0d = %h",
                       $time, wb_count, wb_rd, wb_data, exp_rd, exp_val);
              error_count++;
            end
            exp_halt = model_next_write(exp_rd, exp_val);
          end
        end
      end
      if (!halted) begin
        $display("halted never rose, no write-back for %0d cycles", WB_LIMIT);
        error_count++;
      end else begin
        if (!exp_halt) begin
          $display("Mismatch at %0t: halted rose after %0d write-backs, the model expects more",
                   $time, wb_count);
          error_count++;
        end
        for (int i = 0; i < QUIET_CYCLES; i++) begin
          @(negedge clk);
          if (wb_valid !== 1'b0 || halted !== 1'b1) begin
            $display("Mismatch at %0t: write-back or halt drop seen after halt", $time);
            error_count++;
          end
        end
      end
    end
    check_done = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam int          PROG_WORDS = 48;
  localparam int          DMEM_WORDS = 64;
  localparam int          RUN_CYCLES = 3000;           // limit on the whole run
  localparam logic [31:0] NOP        = 32'h0000_0013;  // addi x0, x0, 0
  localparam logic [31:0] ECALL      = 32'h0000_0073;
  // funct3 per alu choice: add, sub, slt, xor, or, and
  localparam logic [17:0] R_F3 = {3'b111, 3'b110, 3'b100, 3'b010, 3'b000, 3'b000};

  logic                          clk;
  logic                          reset;
  logic [rv_pkg::XLEN-1:0]       imem_data;
  logic [rv_pkg::XLEN-1:0]       imem_addr;
  logic                          wb_valid;
  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd;
  logic [rv_pkg::XLEN-1:0]       wb_data;
  logic                          halted;
  logic [rv_pkg::XLEN-1:0]       program_mem [PROG_WORDS];
  logic [31:0]                   lcg_state;
  logic                          check_done;
  int                            error_count;
  int                            wb_count;
  int                            wait_cycles;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int pick(input int n);  // 0 .. n-1
    return int'(lcg_next() >> 16) % n;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};  // sw
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
  endfunction

  task automatic build_program();
    int         target;
    int         alu;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    for (int i = 1; i <= 8; i++) begin
      program_mem[i-1] = enc_i(12'(pick(4096)), 5'd0, 3'b000, 5'(i), rv_pkg::OPC_OP_IMM);
    end
    program_mem[8]  = enc_s(12'd16, 5'd3, 5'd0);                             // sw x3, 16(x0)
    program_mem[9]  = enc_i(12'd16, 5'd0, 3'b010, 5'd4, rv_pkg::OPC_LOAD);  // lw x4, 16(x0)
    program_mem[10] = enc_r(7'h00, 5'd4, 5'd4, 3'b000, 5'd5);               // load-use add
    for (int i = 11; i < PROG_WORDS - 2; i++) begin
      rd     = 5'(1 + pick(8));
      rs1    = 5'(1 + pick(8));
      rs2    = 5'(1 + pick(8));
      target = i + 2 + pick(3);  // forward only, skips 1 to 3
      if (target > PROG_WORDS - 2) begin
        target = PROG_WORDS - 2;  // never past the final addi x17
      end
      case (pick(10))
        0, 1, 2, 3: begin
          alu = pick(6);
          program_mem[i] = enc_r((alu == 1) ? 7'h20 : 7'h00, rs2, rs1, R_F3[alu*3 +: 3], rd);
        end
        4, 5:    program_mem[i] = enc_i(12'(pick(4096)), rs1, 3'b000, rd, rv_pkg::OPC_OP_IMM);
        6:       program_mem[i] = enc_i(12'(4 * pick(8)), 5'd0, 3'b010, rd, rv_pkg::OPC_LOAD);
        7:       program_mem[i] = enc_s(12'(4 * pick(8)), rs2, 5'd0);
        8:       program_mem[i] = enc_b(13'(4 * (target - i)), rs2, rs1, 3'(pick(2)));
        default: program_mem[i] = enc_j(21'(4 * (target - i)), rd);
      endcase
    end
    program_mem[24]           = ECALL;  // x17 still 0 here, no halt
    program_mem[PROG_WORDS-2] = enc_i(12'd10, 5'd0, 3'b000, 5'd17, rv_pkg::OPC_OP_IMM);
    program_mem[PROG_WORDS-1] = ECALL;  // exit
  endtask

  always #2 clk = ~clk;

  // instruction memory, same-cycle read
  assign imem_data = ((imem_addr >> 2) < PROG_WORDS) ? program_mem[imem_addr >> 2] : NOP;

  rv_core #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_rv_core (
    .clk       (clk),
    .reset     (reset),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .halted    (halted)
  );

  tb_rv_checker #(
    .PROG_WORDS (PROG_WORDS),
    .DMEM_WORDS (DMEM_WORDS)
  ) u_checker (
    .clk         (clk),
    .reset       (reset),
    .program_mem (program_mem),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .halted      (halted),
    .check_done  (check_done),
    .error_count (error_count),
    .wb_count    (wb_count)
  );

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    lcg_state = 32'd68;
    build_program();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    wait_cycles = 0;
    while (!check_done && wait_cycles < RUN_CYCLES) begin
      @(posedge clk);  // checker updates on the falling edge
      wait_cycles++;
    end
    if (!check_done) begin
      $display("checker did not finish within %0d cycles", RUN_CYCLES);
    end
    $display("closing: %0d errors, %0d write-backs checked", error_count, wb_count);
    if (!check_done || error_count != 0) begin
      $display("ERRORS FOUND");
    end else begin
      $display("NO ERRORS");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_memory.sv
rv_core.sv
tb_rv_checker.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_fetch.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_memory.sv
  - rv_core.sv
  - target: test
    files:
      - tb_rv_checker.sv
      - tb_rv_core.sv
